//--- fm_mmr.f
logic/fm_pkg.sv
logic/fm_bus_port.sv
logic/fm_clk_div.sv
logic/fm_global_regs.sv
logic/fm_ch3_freq.sv
logic/fm_update_decode.sv
logic/fm_mmr.sv
tests/fm_mmr_props.sv
tests/fm_mmr_checker.sv
tests/fm_mmr_tb.sv

//--- logic/fm_bus_port.sv
/*
 * CPU port: register number latch, data capture and busy flag
 */
module fm_bus_port (
    input  logic            clk,
    input  logic            rst,
    input  logic [7:0]      din,
    input  logic            write,
    input  logic [1:0]      addr,
    input  logic            clk_en,
    output fm_pkg::bus_wr_t bus_wr,
    output logic            busy
);

    logic              old_write;
    logic              wr_valid;
    logic              part_q;
    fm_pkg::reg_addr_u sel_q;
    logic [7:0]        data_q;
    logic [4:0]        busy_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            old_write <= 1'b0;
            wr_valid  <= 1'b0;
        end else begin
            old_write <= write;
            wr_valid  <= write && addr[0];
        end
    end

    // Register number and payload
    always_ff @(posedge clk) begin
        if (write && !addr[0]) begin
            sel_q  <= din;
            part_q <= addr[1];
        end
        if (write && addr[0])
            data_q <= din;
    end

    assign bus_wr = '{valid: wr_valid, part: part_q, sel: sel_q, data: data_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            busy_cnt <= 5'd0;
        end else if (!old_write && write && addr[0]) begin // Data writes only
            busy     <= 1'b1;
            busy_cnt <= 5'd0;
        end else if (clk_en) begin
            if (busy_cnt == 5'(fm_pkg::BUSY_CYCLES - 1))
                busy <= 1'b0;
            busy_cnt <= busy_cnt + 5'd1;
        end
    end

endmodule

//--- logic/fm_ch3_freq.sv
/*
 * Shared frequency-high latch and channel 3 per-operator frequencies
 */
module fm_ch3_freq (
    input  logic              clk,
    input  logic              rst,
    input  fm_pkg::bus_wr_t   bus_wr,
    output fm_pkg::ch3_freq_t ch3_freq,
    output logic [5:0]        fnum_hi
);

    always_ff @(posedge clk) begin
        if (rst) begin
            ch3_freq <= '0;
            fnum_hi  <= 6'd0;
        end else if (bus_wr.valid) begin
            case (bus_wr.sel.num)
                // One latch for every channel, either bank
                8'hA4, 8'hA5, 8'hA6, 8'hAC, 8'hAD, 8'hAE:
                    fnum_hi <= bus_wr.data[5:0];
                fm_pkg::REG_CH3_OP1:
                    {ch3_freq.block_op1, ch3_freq.fnum_op1} <= {fnum_hi, bus_wr.data};
                fm_pkg::REG_CH3_OP2:
                    {ch3_freq.block_op2, ch3_freq.fnum_op2} <= {fnum_hi, bus_wr.data};
                fm_pkg::REG_CH3_OP3:
                    {ch3_freq.block_op3, ch3_freq.fnum_op3} <= {fnum_hi, bus_wr.data};
                default: ;
            endcase
        end
    end

endmodule

//--- logic/fm_clk_div.sv
/*
 * Prescaler making the synthesis clock enable out of cen
 */
module fm_clk_div (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic [1:0] div_setting,
    output logic       clk_en
);

    logic [2:0] cnt;
    logic [2:0] last;     // Divisor minus one
    logic [1:0] old_setting;

    always_comb begin
        case (div_setting)
            2'b11:   last = 3'd5;
            2'b00:   last = 3'd1;
            default: last = 3'd2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt         <= 3'd0;
            old_setting <= 2'b11;
        end else begin
            old_setting <= div_setting;
            if (div_setting != old_setting)
                cnt <= 3'd0;      // Restart on a new divisor
            else if (cen)
                cnt <= (cnt >= last) ? 3'd0 : cnt + 3'd1;
        end
    end

    assign clk_en = cen && (cnt == last);

endmodule

//--- logic/fm_global_regs.sv
/*
 * Global registers 21-2F: test bits, LFO, timers, mode, DAC and divider select
 */
module fm_global_regs (
    input  logic               clk,
    input  logic               rst,
    input  fm_pkg::bus_wr_t    bus_wr,
    input  logic               clk_en,
    output fm_pkg::timer_cfg_t timer_cfg,
    output fm_pkg::mode_cfg_t  mode_cfg,
    output fm_pkg::dac_t       dac,
    output logic [1:0]         div_setting
);

    logic       lower;
    logic [7:0] d;

    assign lower = bus_wr.valid && !bus_wr.part;
    assign d     = bus_wr.data;

    always_ff @(posedge clk) begin
        if (rst) begin
            timer_cfg   <= '0;
            mode_cfg    <= '0;
            dac         <= '0;
            div_setting <= 2'b11;
        end else if (bus_wr.valid) begin
            if (lower) begin
                case (bus_wr.sel.num)
                    fm_pkg::REG_TESTYM: begin
                        mode_cfg.eg_stop     <= d[5];
                        mode_cfg.pg_stop     <= d[3];
                        mode_cfg.fast_timers <= d[2];
                    end
                    fm_pkg::REG_LFO:   {mode_cfg.lfo_en, mode_cfg.lfo_freq} <= d[3:0];
                    fm_pkg::REG_CLKA1: timer_cfg.value_a[9:2] <= d;
                    fm_pkg::REG_CLKA2: timer_cfg.value_a[1:0] <= d[1:0];
                    fm_pkg::REG_CLKB:  timer_cfg.value_b      <= d;
                    fm_pkg::REG_TIMER: begin
                        mode_cfg.effect      <= |d[7:6];
                        mode_cfg.csm         <= d[7:6] == 2'b10;
                        timer_cfg.clr_flag_b <= d[5];
                        timer_cfg.clr_flag_a <= d[4];
                        timer_cfg.irq_en_b   <= d[3];
                        timer_cfg.irq_en_a   <= d[2];
                        timer_cfg.load_b     <= d[1];
                        timer_cfg.load_a     <= d[0];
                    end
                    fm_pkg::REG_PCM:     dac.pcm    <= {~d[7], d[6:0], 1'b1};
                    fm_pkg::REG_PCM_EN:  dac.pcm_en <= d[7];
                    fm_pkg::REG_DACTEST: dac.pcm[0] <= d[3];
                    fm_pkg::REG_CLK_N6:  div_setting[1] <= 1'b1;
                    fm_pkg::REG_CLK_N3:  div_setting[0] <= 1'b1;
                    fm_pkg::REG_CLK_N2:  div_setting    <= 2'b00;
                    default: ;
                endcase
            end
            dac.pcm_wr <= lower && (bus_wr.sel.num == fm_pkg::REG_PCM);
        end else if (clk_en) begin
            // One-shot bits go away on the first idle enable
            timer_cfg.clr_flag_a <= 1'b0;
            timer_cfg.clr_flag_b <= 1'b0;
            dac.pcm_wr           <= 1'b0;
        end
    end

endmodule

//--- logic/fm_mmr.sv
/*
 * FM register interface top: bus port, prescaler and register blocks
 */
module fm_mmr (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic [7:0]         din,
    input  logic               write,
    input  logic [1:0]         addr,
    output logic               busy,
    output logic               clk_en,
    output fm_pkg::timer_cfg_t timer_cfg,
    output fm_pkg::mode_cfg_t  mode_cfg,
    output fm_pkg::dac_t       dac,
    output fm_pkg::ch3_freq_t  ch3_freq,
    output fm_pkg::slot_upd_t  slot_upd
);

    fm_pkg::bus_wr_t bus_wr;
    logic [1:0]      div_setting;
    logic [5:0]      fnum_hi;

    fm_bus_port u_bus_port (
        .clk    (clk),
        .rst    (rst),
        .din    (din),
        .write  (write),
        .addr   (addr),
        .clk_en (clk_en),
        .bus_wr (bus_wr),
        .busy   (busy)
    );

    fm_clk_div u_clk_div (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .div_setting (div_setting),
        .clk_en      (clk_en)
    );

    fm_global_regs u_global_regs (
        .clk         (clk),
        .rst         (rst),
        .bus_wr      (bus_wr),
        .clk_en      (clk_en),
        .timer_cfg   (timer_cfg),
        .mode_cfg    (mode_cfg),
        .dac         (dac),
        .div_setting (div_setting)
    );

    fm_ch3_freq u_ch3_freq (
        .clk      (clk),
        .rst      (rst),
        .bus_wr   (bus_wr),
        .ch3_freq (ch3_freq),
        .fnum_hi  (fnum_hi)
    );

    fm_update_decode u_update_decode (
        .clk      (clk),
        .rst      (rst),
        .bus_wr   (bus_wr),
        .fnum_hi  (fnum_hi),
        .slot_upd (slot_upd)
    );

endmodule

//--- logic/fm_pkg.sv
/*
 * Register numbers, counts and shared types for the FM register interface
 */
package fm_pkg;

    // Global registers, lower bank
    localparam logic [7:0] REG_TESTYM  = 8'h21;
    localparam logic [7:0] REG_LFO     = 8'h22;
    localparam logic [7:0] REG_CLKA1   = 8'h24;
    localparam logic [7:0] REG_CLKA2   = 8'h25;
    localparam logic [7:0] REG_CLKB    = 8'h26;
    localparam logic [7:0] REG_TIMER   = 8'h27;
    localparam logic [7:0] REG_KON     = 8'h28;
    localparam logic [7:0] REG_PCM     = 8'h2A;
    localparam logic [7:0] REG_PCM_EN  = 8'h2B;
    localparam logic [7:0] REG_DACTEST = 8'h2C;
    localparam logic [7:0] REG_CLK_N6  = 8'h2D;
    localparam logic [7:0] REG_CLK_N3  = 8'h2E;
    localparam logic [7:0] REG_CLK_N2  = 8'h2F;

    // Channel 3 special frequency registers
    localparam logic [7:0] REG_CH3_OP1 = 8'hA9;
    localparam logic [7:0] REG_CH3_OP2 = 8'hAA;
    localparam logic [7:0] REG_CH3_OP3 = 8'hA8;

    localparam int BUSY_CYCLES = 32; // Synthesis clock enables per write

    typedef logic [10:0] fnum_t;
    typedef logic [2:0]  block_t;

    // Slot view of a register number
    typedef struct packed {
        logic [3:0] group;
        logic [1:0] op;
        logic [1:0] ch;
    } reg_slot_t;

    typedef union packed {
        logic [7:0] num;
        reg_slot_t  slot;
    } reg_addr_u;

    typedef struct packed {
        logic       valid;
        logic       part;       // Upper bank when set
        reg_addr_u  sel;
        logic [7:0] data;
    } bus_wr_t;

    typedef struct packed {
        logic [9:0] value_a;
        logic [7:0] value_b;
        logic       clr_flag_b;
        logic       clr_flag_a;
        logic       irq_en_b;
        logic       irq_en_a;
        logic       load_b;
        logic       load_a;
    } timer_cfg_t;

    typedef struct packed {
        logic       csm;
        logic       effect;
        logic       fast_timers;
        logic       eg_stop;
        logic       pg_stop;
        logic       lfo_en;
        logic [2:0] lfo_freq;
    } mode_cfg_t;

    typedef struct packed {
        logic [8:0] pcm;
        logic       pcm_en;
        logic       pcm_wr;
    } dac_t;

    typedef struct packed {
        block_t block_op1;
        fnum_t  fnum_op1;
        block_t block_op2;
        fnum_t  fnum_op2;
        block_t block_op3;
        fnum_t  fnum_op3;
    } ch3_freq_t;

    typedef struct packed {
        logic [2:0] up_chreg;   // fnum-low, alg, pms
        logic [6:0] up_opreg;   // dt1, tl, ks_ar, amen_dr, sr, sl_rr, ssgeg
        logic       up_keyon;
        logic [2:0] ch;
        logic [1:0] op;
        logic [5:0] fnum_hi;
        logic [7:0] din;
    } slot_upd_t;

endpackage

//--- logic/fm_update_decode.sv
/*
 * Data write decode into slot register update strobes, channel and operator
 */
module fm_update_decode (
    input  logic              clk,
    input  logic              rst,
    input  fm_pkg::bus_wr_t   bus_wr,
    input  logic [5:0]        fnum_hi,
    output fm_pkg::slot_upd_t slot_upd
);

    fm_pkg::reg_slot_t slot;
    logic [2:0]        up_chreg;
    logic [6:0]        up_opreg;
    logic              up_keyon;
    logic [2:0]        ch_q;
    logic [1:0]        op_q;
    logic [5:0]        fnum_hi_q;
    logic [7:0]        din_q;

    assign slot = bus_wr.sel.slot;

    always_ff @(posedge clk) begin
        if (rst) begin
            up_chreg <= 3'd0;
            up_opreg <= 7'd0;
            up_keyon <= 1'b0;
        end else if (bus_wr.valid) begin
            up_keyon <= bus_wr.sel.num == fm_pkg::REG_KON;
            up_chreg <= 3'd0;
            up_opreg <= 7'd0;
            if (slot.ch != 2'b11) begin // Channel slot 3 does not exist
                case (slot.group)
                    4'h3, 4'h4, 4'h5, 4'h6, 4'h7, 4'h8, 4'h9:
                        up_opreg <= 7'd1 << (slot.group - 4'd3);
                    4'hA: if (slot.op == 2'd0) up_chreg <= 3'b001;  // fnum low
                    4'hB: begin
                        if (slot.op == 2'd0)
                            up_chreg <= 3'b010;                     // FB and algorithm
                        else if (slot.op == 2'd1)
                            up_chreg <= 3'b100;                     // PMS
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus_wr.valid) begin
            ch_q      <= {bus_wr.part, slot.ch};
            op_q      <= slot.op;
            fnum_hi_q <= fnum_hi;
            din_q     <= bus_wr.data;
        end
    end

    assign slot_upd = '{
        up_chreg: up_chreg,
        up_opreg: up_opreg,
        up_keyon: up_keyon,
        ch:       ch_q,
        op:       op_q,
        fnum_hi:  fnum_hi_q,
        din:      din_q
    };

endmodule

//--- tests/fm_mmr_checker.sv
/*
 * Scoreboard: shadow register state, reference write function,
 * busy and clock enable models, error counting
 */
module fm_mmr_checker (
    input logic               clk,
    input logic               rst,
    input logic               write,
    input logic [1:0]         addr,
    input logic [7:0]         din,
    input logic               busy,
    input logic               clk_en,
    input fm_pkg::timer_cfg_t timer_cfg,
    input fm_pkg::mode_cfg_t  mode_cfg,
    input fm_pkg::dac_t       dac,
    input fm_pkg::ch3_freq_t  ch3_freq,
    input fm_pkg::slot_upd_t  slot_upd
);

    typedef struct packed {
        fm_pkg::timer_cfg_t timer;
        fm_pkg::mode_cfg_t  mode;
        fm_pkg::dac_t       dac;
        logic [1:0]         div;
        fm_pkg::ch3_freq_t  ch3;
        logic [5:0]         hi;     // Shared fnum high latch
        fm_pkg::slot_upd_t  upd;
    } shadow_t;

    int error_count = 0;
    int check_count = 0;

    shadow_t    exp_s;
    shadow_t    nxt;
    logic       exp_busy;
    int         en_cnt;             // Enables since the last data write
    logic       pend_valid;         // Data write seen, applied on the next edge
    logic       pend_part;
    logic [7:0] pend_num;
    logic [7:0] pend_data;
    logic       lat_part;
    logic [7:0] lat_num;
    logic       old_wr;
    logic       upd_seen;           // A write has reached slot_upd
    int         gap;
    logic       div_moved;

    function automatic int divisor(input logic [1:0] setting);
        case (setting)
            2'b11:   return 6;
            2'b00:   return 2;
            default: return 3;
        endcase
    endfunction

    function automatic shadow_t apply_write(input logic part, input logic [7:0] num,
                                            input logic [7:0] d, input shadow_t s);
        shadow_t n;
        n = s;
        if (!part) begin
            case (num)
                fm_pkg::REG_TESTYM: {n.mode.eg_stop, n.mode.pg_stop, n.mode.fast_timers} =
                                    {d[5], d[3], d[2]};
                fm_pkg::REG_LFO:    {n.mode.lfo_en, n.mode.lfo_freq} = d[3:0];
                fm_pkg::REG_CLKA1:  n.timer.value_a = {d, s.timer.value_a[1:0]};
                fm_pkg::REG_CLKA2:  n.timer.value_a = {s.timer.value_a[9:2], d[1:0]};
                fm_pkg::REG_CLKB:   n.timer.value_b = d;
                fm_pkg::REG_TIMER: begin
                    n.mode.effect = d[7] | d[6];
                    n.mode.csm    = d[7] & ~d[6];
                    {n.timer.clr_flag_b, n.timer.clr_flag_a} = d[5:4];
                    {n.timer.irq_en_b, n.timer.irq_en_a}     = d[3:2];
                    {n.timer.load_b, n.timer.load_a}         = d[1:0];
                end
                fm_pkg::REG_PCM:     n.dac.pcm = {d ^ 8'h80, 1'b1};
                fm_pkg::REG_PCM_EN:  n.dac.pcm_en = d[7];
                fm_pkg::REG_DACTEST: n.dac.pcm[0] = d[3];
                fm_pkg::REG_CLK_N6:  n.div = s.div | 2'b10;
                fm_pkg::REG_CLK_N3:  n.div = s.div | 2'b01;
                fm_pkg::REG_CLK_N2:  n.div = 2'b00;
                default: ;
            endcase
        end
        n.dac.pcm_wr = !part && num == fm_pkg::REG_PCM;
        // Frequency latch and channel 3 pairs, either bank
        if (num inside {[8'hA4:8'hA6], [8'hAC:8'hAE]})
            n.hi = d[5:0];
        if (num == fm_pkg::REG_CH3_OP1)
            {n.ch3.block_op1, n.ch3.fnum_op1} = {s.hi, d};
        if (num == fm_pkg::REG_CH3_OP2)
            {n.ch3.block_op2, n.ch3.fnum_op2} = {s.hi, d};
        if (num == fm_pkg::REG_CH3_OP3)
            {n.ch3.block_op3, n.ch3.fnum_op3} = {s.hi, d};
        n.upd = '{up_chreg: 3'd0, up_opreg: 7'd0, up_keyon: num == fm_pkg::REG_KON,
                  ch: {part, num[1:0]}, op: num[3:2], fnum_hi: s.hi, din: d};
        if (num[1:0] != 2'b11) begin
            if (num[7:4] >= 4'h3 && num[7:4] <= 4'h9)
                n.upd.up_opreg[num[7:4] - 4'h3] = 1'b1;
            else if (num inside {[8'hA0:8'hA2]})
                n.upd.up_chreg[0] = 1'b1;
            else if (num inside {[8'hB0:8'hB2]})
                n.upd.up_chreg[1] = 1'b1;
            else if (num inside {[8'hB4:8'hB6]})
                n.upd.up_chreg[2] = 1'b1;
        end
        return n;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            exp_s      = '0;
            exp_s.div  = 2'b11;
            exp_busy   = 1'b0;
            en_cnt     = 0;
            pend_valid = 1'b0;
            old_wr     = 1'b0;
            upd_seen   = 1'b0;
            gap        = 0;
            div_moved  = 1'b1;          // First interval after reset is not aligned
        end else begin
            // DUT values here are the ones left by the previous edge
            check_value("timer_cfg", exp_s.timer, timer_cfg);
            check_value("mode_cfg", exp_s.mode, mode_cfg);
            check_value("dac", exp_s.dac, dac);
            check_value("ch3_freq", exp_s.ch3, ch3_freq);
            check_value("busy", exp_busy, busy);
            if (upd_seen)
                check_value("slot_upd", exp_s.upd, slot_upd);
            else
                check_value("slot_upd strobes",
                            {exp_s.upd.up_chreg, exp_s.upd.up_opreg, exp_s.upd.up_keyon},
                            {slot_upd.up_chreg, slot_upd.up_opreg, slot_upd.up_keyon});

            gap = gap + 1;
            if (clk_en) begin
                if (!div_moved)
                    check_value("clk_en spacing", divisor(exp_s.div), gap);
                gap       = 0;
                div_moved = 1'b0;
            end

            // Busy drops on the 32nd enable after the latest data write
            if (write && addr[0] && !old_wr) begin
                exp_busy = 1'b1;
                en_cnt   = 0;
            end else if (clk_en) begin
                en_cnt = en_cnt + 1;
                if (en_cnt == fm_pkg::BUSY_CYCLES)
                    exp_busy = 1'b0;
            end

            if (pend_valid) begin
                nxt = apply_write(pend_part, pend_num, pend_data, exp_s);
                if (nxt.div != exp_s.div)
                    div_moved = 1'b1;
                exp_s    = nxt;
                upd_seen = 1'b1;
            end else if (clk_en) begin
                exp_s.timer.clr_flag_a = 1'b0;
                exp_s.timer.clr_flag_b = 1'b0;
                exp_s.dac.pcm_wr       = 1'b0;
            end

            pend_valid = write && addr[0];
            if (write && !addr[0]) begin
                lat_num  = din;
                lat_part = addr[1];
            end
            if (write && addr[0]) begin
                pend_num  = lat_num;
                pend_part = lat_part;
                pend_data = din;
            end
            old_wr = write;
        end
    end

endmodule

//--- tests/fm_mmr_props.sv
/*
 * Concurrent assertions on the bus strobe, update strobes and busy, bound to fm_mmr
 */
module fm_mmr_props (
    input logic              clk,
    input logic              rst,
    input logic              write,
    input logic [1:0]        addr,
    input logic              busy,
    input fm_pkg::bus_wr_t   bus_wr,
    input fm_pkg::slot_upd_t slot_upd
);

    int fail_count = 0;

    valid_one_cycle: assert property (@(posedge clk) disable iff (rst)
        bus_wr.valid |=> !bus_wr.valid)
        else begin
            $error("bus_wr valid held for more than one clock");
            fail_count++;
        end

    // Channel and operator strobes share one slot register port
    strobe_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({slot_upd.up_chreg, slot_upd.up_opreg}))
        else begin
            $error("more than one update strobe high");
            fail_count++;
        end

    busy_cause: assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> $past(write && addr[0]))
        else begin
            $error("busy rose without a data write");
            fail_count++;
        end

endmodule

bind fm_mmr fm_mmr_props u_props (
    .clk      (clk),
    .rst      (rst),
    .write    (write),
    .addr     (addr),
    .busy     (busy),
    .bus_wr   (bus_wr),
    .slot_upd (slot_upd)
);

//--- tests/fm_mmr_tb.sv
/*
 * Testbench top: clock, reset, directed and seeded random CPU writes, summary
 */
module fm_mmr_tb;

    localparam int BUSY_LIMIT = 32 * 6 + 20;  // Slowest divisor plus margin

    logic               clk;
    logic               rst;
    logic               cen;
    logic [7:0]         din;
    logic               write;
    logic [1:0]         addr;
    logic               busy;
    logic               clk_en;
    fm_pkg::timer_cfg_t timer_cfg;
    fm_pkg::mode_cfg_t  mode_cfg;
    fm_pkg::dac_t       dac;
    fm_pkg::ch3_freq_t  ch3_freq;
    fm_pkg::slot_upd_t  slot_upd;

    int         writes   = 0;
    int         timeouts = 0;
    int         first_draw;
    int         total_errors;
    logic [7:0] rnd_num;
    logic       rnd_part;

    fm_mmr dut (.*);

    fm_mmr_checker chk (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Address cycle, idle, data cycle, idle
    task automatic cpu_write(input logic part, input logic [7:0] num, input logic [7:0] data);
        @(posedge clk);
        write <= 1'b1;
        addr  <= {part, 1'b0};
        din   <= num;
        @(posedge clk);
        write <= 1'b0;
        @(posedge clk);
        write <= 1'b1;
        addr  <= {part, 1'b1};
        din   <= data;
        @(posedge clk);
        write <= 1'b0;
        writes++;
    endtask

    function automatic logic [7:0] pick_register();
        case ($urandom_range(0, 4))
            0:       return 8'h21 + 8'($urandom_range(0, 14));   // Globals
            1:       return 8'hA0 + 8'($urandom_range(0, 15));   // Frequency group
            2, 3:    return 8'h30 + 8'($urandom_range(0, 135));  // Slot registers
            default: return 8'($urandom());
        endcase
    endfunction

    task automatic wait_busy_clear(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (busy !== 1'b0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (busy !== 1'b0) begin
            timeouts++;
            $display("Timeout: busy still set after %0d clocks", limit);
        end
    endtask

    task automatic wait_clk_en(input int count, input int limit);
        int seen;
        int n;
        seen = 0;
        n    = 0;
        while (seen < count && n < limit) begin
            @(negedge clk);
            if (clk_en)
                seen++;
            n++;
        end
        if (seen < count) begin
            timeouts++;
            $display("Timeout: only %0d of %0d clock enables seen", seen, count);
        end
    endtask

    initial begin
        first_draw = $urandom(32'hcc2c0e72);
        rst   = 1'b1;
        cen   = 1'b1;
        write = 1'b0;
        addr  = 2'b00;
        din   = 8'h00;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // Busy length at the reset divisor
        cpu_write(1'b0, 8'h40, 8'h5A);
        wait_busy_clear(BUSY_LIMIT);

        // Several latch writes before the channel 3 registers
        cpu_write(1'b0, 8'hA4, 8'h15);
        cpu_write(1'b1, 8'hA5, 8'h2E);
        cpu_write(1'b0, 8'hAD, 8'h3B);
        cpu_write(1'b0, fm_pkg::REG_CH3_OP1, 8'hC3);
        cpu_write(1'b1, 8'hAC, 8'h07);
        cpu_write(1'b0, fm_pkg::REG_CH3_OP2, 8'h99);
        cpu_write(1'b1, fm_pkg::REG_CH3_OP3, 8'h21);

        // DAC sample, bit 0 override and enable
        cpu_write(1'b0, fm_pkg::REG_PCM, 8'h80);
        cpu_write(1'b0, fm_pkg::REG_DACTEST, 8'h00);
        cpu_write(1'b0, fm_pkg::REG_PCM_EN, 8'h80);
        cpu_write(1'b0, fm_pkg::REG_PCM, 8'h7F);
        wait_busy_clear(BUSY_LIMIT);

        repeat (400) begin
            rnd_num  = pick_register();
            rnd_part = ($urandom_range(0, 3) == 0);
            cpu_write(rnd_part, rnd_num, 8'($urandom()));
            repeat ($urandom_range(0, 5)) @(posedge clk);
        end
        wait_busy_clear(BUSY_LIMIT);

        // Divisor 2, then 3
        cpu_write(1'b0, fm_pkg::REG_CLK_N2, 8'h00);
        wait_clk_en(5, 40);
        cpu_write(1'b0, fm_pkg::REG_CLK_N3, 8'h00);
        wait_clk_en(5, 40);
        wait_busy_clear(BUSY_LIMIT);

        total_errors = chk.error_count + dut.u_props.fail_count + timeouts;
        $display("Summary: %0d writes, %0d checks, %0d errors, %0d assert fails, %0d timeouts",
                 writes, chk.check_count, chk.error_count, dut.u_props.fail_count, timeouts);
        if (total_errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule
